/* hw/cache_params.svh */
// Cache geometry and field widths
// Four-way set-associative write-back cache, word addressed

`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Word address and data word
`define CACHE_ADDR_WIDTH 16
`define CACHE_WORD_WIDTH 32

// Geometry
`define CACHE_WORDS_PER_LINE 4
`define CACHE_NUM_SETS 16
`define CACHE_NUM_WAYS 4

// Address fields, offset low, index next, tag high
`define CACHE_OFFSET_WIDTH 2
`define CACHE_INDEX_WIDTH 4
`define CACHE_TAG_WIDTH 10

`define CACHE_WAY_WIDTH 2 // Way number

`endif

/* hw/cache_pkg.sv */
// Cache shared types
// Address field types, way and age types, the line union and the controller states

`default_nettype none

`include "cache_params.svh"

package cache_pkg;

	typedef logic [`CACHE_TAG_WIDTH-1:0] tag_t;
	typedef logic [`CACHE_INDEX_WIDTH-1:0] index_t;
	typedef logic [`CACHE_OFFSET_WIDTH-1:0] offset_t;
	typedef logic [`CACHE_WAY_WIDTH-1:0] way_t;
	typedef logic [1:0] age_t; // Highest value is most recent

	// Flat view for memory transfers, word view for word access
	typedef union packed {
		logic [`CACHE_WORDS_PER_LINE*`CACHE_WORD_WIDTH-1:0] flat;
		logic [`CACHE_WORDS_PER_LINE-1:0][`CACHE_WORD_WIDTH-1:0] words; // Word 0 at low end
	} line_u;

	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		WRITE_BACK,
		FILL
	} ctrl_state_t;

endpackage

`default_nettype wire

/* hw/cache_way.sv */
// Cache way storage
// Tag, valid, dirty, LRU age and line data of one way for every set.
// Arrays are read asynchronously at the current index

`default_nettype none

`include "cache_params.svh"

module cache_way (
	input  logic                          clk,
	input  logic                          reset,
	input  cache_pkg::index_t             index,
	input  cache_pkg::tag_t               lookup_tag,
	input  logic                          way_sel,
	input  logic                          touch,
	input  cache_pkg::age_t               touched_age,
	input  logic                          fill,
	input  cache_pkg::tag_t               fill_tag,
	input  cache_pkg::line_u              fill_line,
	input  logic                          write_word,
	input  cache_pkg::offset_t            word_offset,
	input  logic [`CACHE_WORD_WIDTH-1:0]  word_data,
	input  logic                          clean,
	output logic                          hit,
	output logic                          valid,
	output logic                          dirty,
	output cache_pkg::age_t               age,
	output cache_pkg::tag_t               stored_tag,
	output cache_pkg::line_u              line
);

	cache_pkg::tag_t  tags [`CACHE_NUM_SETS];
	cache_pkg::line_u data [`CACHE_NUM_SETS];
	cache_pkg::age_t  ages [`CACHE_NUM_SETS];
	logic             valid_bits [`CACHE_NUM_SETS];
	logic             dirty_bits [`CACHE_NUM_SETS];

	// Per-set state
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
				valid_bits[s] <= 1'b0;
				dirty_bits[s] <= 1'b0;
				ages[s]       <= '0;
			end
		end else begin
			if (touch) begin
				if (way_sel)
					ages[index] <= '1; // Becomes most recent
				else if (ages[index] > touched_age)
					ages[index] <= ages[index] - 1'b1;
			end
			if (way_sel && fill) begin
				valid_bits[index] <= 1'b1;
				dirty_bits[index] <= 1'b0;
			end
			if (way_sel && write_word)
				dirty_bits[index] <= 1'b1;
			if (way_sel && clean)
				dirty_bits[index] <= 1'b0; // Line written back
		end
	end

	// Tag and line data
	always_ff @(posedge clk) begin
		if (way_sel && fill) begin
			tags[index] <= fill_tag;
			data[index] <= fill_line;
		end
		if (way_sel && write_word)
			data[index].words[word_offset] <= word_data;
	end

	assign valid      = valid_bits[index];
	assign dirty      = dirty_bits[index];
	assign age        = ages[index];
	assign stored_tag = tags[index];
	assign line       = data[index];
	assign hit        = valid_bits[index] && (tags[index] == lookup_tag);

endmodule

`default_nettype wire

/* hw/way_select.sv */
// Hit and victim selector
// Reduces the per-way lookup results to the hit way, the victim way and their data

`default_nettype none

`include "cache_params.svh"

module way_select (
	input  logic [`CACHE_NUM_WAYS-1:0] way_hit,
	input  logic [`CACHE_NUM_WAYS-1:0] way_valid,
	input  logic [`CACHE_NUM_WAYS-1:0] way_dirty,
	input  cache_pkg::age_t            way_age [`CACHE_NUM_WAYS],
	input  cache_pkg::tag_t            way_tag [`CACHE_NUM_WAYS],
	input  cache_pkg::line_u           way_line [`CACHE_NUM_WAYS],
	input  cache_pkg::way_t            touch_way,
	output logic                       hit,
	output cache_pkg::way_t            hit_way,
	output cache_pkg::line_u           hit_line,
	output cache_pkg::way_t            victim_way,
	output logic                       victim_dirty,
	output cache_pkg::tag_t            victim_tag,
	output cache_pkg::line_u           victim_line,
	output cache_pkg::age_t            touched_age
);

	logic victim_found;

	// At most one way hits in a set
	always_comb begin
		hit     = 1'b0;
		hit_way = '0;
		for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
			if (way_hit[w]) begin
				hit     = 1'b1;
				hit_way = cache_pkg::way_t'(w);
			end
		end
	end

	// Lowest invalid way first, otherwise the least recent one
	always_comb begin
		victim_found = 1'b0;
		victim_way   = '0;
		for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
			if (!way_valid[w] && !victim_found) begin
				victim_found = 1'b1;
				victim_way   = cache_pkg::way_t'(w);
			end
		end
		for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
			if (way_age[w] == '0 && !victim_found) begin
				victim_found = 1'b1;
				victim_way   = cache_pkg::way_t'(w);
			end
		end
	end

	assign hit_line     = way_line[hit_way];
	assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];
	assign victim_tag   = way_tag[victim_way];
	assign victim_line  = way_line[victim_way];
	assign touched_age  = way_age[touch_way]; // Old age, shared by all ways

endmodule

`default_nettype wire

/* hw/cache_ctrl.sv */
// Cache controller
// Captures one request, runs lookup, write-back and fill, and drives the
// way strobes and the lower-level memory strobes

`default_nettype none

`include "cache_params.svh"

module cache_ctrl (
	input  logic                                          clk,
	input  logic                                          reset,
	// Requester
	input  logic                                          req_valid,
	input  logic                                          req_write,
	input  logic [`CACHE_ADDR_WIDTH-1:0]                  req_addr,
	input  logic [`CACHE_WORD_WIDTH-1:0]                  req_wdata,
	output logic                                          resp_valid,
	output logic [`CACHE_WORD_WIDTH-1:0]                  resp_rdata,
	output logic                                          resp_hit,
	output logic                                          busy,
	// Lower-level memory
	output logic                                          mem_read,
	output logic                                          mem_write,
	output logic [`CACHE_TAG_WIDTH+`CACHE_INDEX_WIDTH-1:0] mem_addr,
	output cache_pkg::line_u                              mem_wdata,
	input  logic                                          mem_rvalid,
	input  cache_pkg::line_u                              mem_rdata,
	// Shared way inputs
	output cache_pkg::index_t                             index,
	output cache_pkg::tag_t                               lookup_tag,
	output cache_pkg::offset_t                            word_offset,
	output logic [`CACHE_WORD_WIDTH-1:0]                  word_data,
	output logic [`CACHE_NUM_WAYS-1:0]                    way_sel,
	output logic                                          touch,
	output cache_pkg::way_t                               touch_way,
	output logic                                          fill,
	output cache_pkg::line_u                              fill_line,
	output logic                                          write_word,
	output logic                                          clean,
	// From the selector
	input  logic                                          hit,
	input  cache_pkg::way_t                               hit_way,
	input  cache_pkg::line_u                              hit_line,
	input  cache_pkg::way_t                               victim_way,
	input  logic                                          victim_dirty,
	input  cache_pkg::tag_t                               victim_tag,
	input  cache_pkg::line_u                              victim_line
);

	cache_pkg::ctrl_state_t state;
	cache_pkg::tag_t        tag_q;
	cache_pkg::index_t      index_q;
	cache_pkg::offset_t     offset_q;
	logic                   write_q;
	logic [`CACHE_WORD_WIDTH-1:0] wdata_q;
	logic                   missed;    // Request needed a fill
	logic                   read_sent; // mem_read already issued in FILL
	logic                   accept;
	cache_pkg::way_t        sel_way;

	assign accept = (state == cache_pkg::IDLE) && req_valid && !resp_valid;
	assign busy   = (state != cache_pkg::IDLE) || resp_valid;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state      <= cache_pkg::IDLE;
			missed     <= 1'b0;
			read_sent  <= 1'b0;
			resp_valid <= 1'b0;
			resp_hit   <= 1'b0;
		end else begin
			resp_valid <= 1'b0;
			case (state)
				cache_pkg::IDLE: begin
					if (accept) begin
						missed <= 1'b0;
						state  <= cache_pkg::LOOKUP;
					end
				end
				cache_pkg::LOOKUP: begin
					if (hit) begin
						resp_valid <= 1'b1;
						resp_hit   <= !missed;
						state      <= cache_pkg::IDLE;
					end else begin
						missed <= 1'b1;
						state  <= victim_dirty ? cache_pkg::WRITE_BACK : cache_pkg::FILL;
					end
				end
				cache_pkg::WRITE_BACK: state <= cache_pkg::FILL; // One write strobe
				cache_pkg::FILL: begin
					read_sent <= 1'b1;
					if (mem_rvalid) begin
						read_sent <= 1'b0;
						state     <= cache_pkg::LOOKUP; // Retry, now hits
					end
				end
				default: state <= cache_pkg::IDLE;
			endcase
		end
	end

	// Request capture and read data
	always_ff @(posedge clk) begin
		if (accept) begin
			tag_q    <= req_addr[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_WIDTH];
			index_q  <= req_addr[`CACHE_OFFSET_WIDTH +: `CACHE_INDEX_WIDTH];
			offset_q <= req_addr[`CACHE_OFFSET_WIDTH-1:0];
			write_q  <= req_write;
			wdata_q  <= req_wdata;
		end
		if (state == cache_pkg::LOOKUP && hit)
			resp_rdata <= write_q ? wdata_q : hit_line.words[offset_q];
	end

	// Hit way in LOOKUP, victim way during write-back and fill
	assign sel_way = (state == cache_pkg::LOOKUP) ? hit_way : victim_way;
	assign way_sel = `CACHE_NUM_WAYS'(1) << sel_way;

	assign index       = index_q;
	assign lookup_tag  = tag_q;
	assign word_offset = offset_q;
	assign word_data   = wdata_q;
	assign touch       = (state == cache_pkg::LOOKUP) && hit;
	assign touch_way   = hit_way;
	assign write_word  = touch && write_q;
	assign fill        = (state == cache_pkg::FILL) && mem_rvalid;
	assign fill_line   = mem_rdata;
	assign clean       = (state == cache_pkg::WRITE_BACK);

	assign mem_write = (state == cache_pkg::WRITE_BACK);
	assign mem_read  = (state == cache_pkg::FILL) && !read_sent;
	assign mem_wdata = victim_line;
	// Victim address rebuilt from its stored tag
	assign mem_addr  = mem_write ? {victim_tag, index_q} : {tag_q, index_q};

endmodule

`default_nettype wire

/* hw/l2_cache.sv */
// Set-associative write-back cache, top level
// Controller, one storage module per way and the hit/victim selector

`default_nettype none

`include "cache_params.svh"

module l2_cache (
	input  logic                                          clk,
	input  logic                                          reset,
	input  logic                                          req_valid,
	input  logic                                          req_write,
	input  logic [`CACHE_ADDR_WIDTH-1:0]                  req_addr,
	input  logic [`CACHE_WORD_WIDTH-1:0]                  req_wdata,
	output logic                                          resp_valid,
	output logic [`CACHE_WORD_WIDTH-1:0]                  resp_rdata,
	output logic                                          resp_hit,
	output logic                                          busy,
	output logic                                          mem_read,
	output logic                                          mem_write,
	output logic [`CACHE_TAG_WIDTH+`CACHE_INDEX_WIDTH-1:0] mem_addr,
	output cache_pkg::line_u                              mem_wdata,
	input  logic                                          mem_rvalid,
	input  cache_pkg::line_u                              mem_rdata
);

	cache_pkg::index_t  index;
	cache_pkg::tag_t    lookup_tag;
	cache_pkg::offset_t word_offset;
	logic [`CACHE_WORD_WIDTH-1:0] word_data;
	logic [`CACHE_NUM_WAYS-1:0]   way_sel;
	logic               touch, fill, write_word, clean;
	cache_pkg::way_t    touch_way;
	cache_pkg::line_u   fill_line;
	cache_pkg::age_t    touched_age;

	// Per-way results
	logic [`CACHE_NUM_WAYS-1:0] way_hit, way_valid, way_dirty;
	cache_pkg::age_t            way_age [`CACHE_NUM_WAYS];
	cache_pkg::tag_t            way_tag [`CACHE_NUM_WAYS];
	cache_pkg::line_u           way_line [`CACHE_NUM_WAYS];

	// Selector results
	logic             hit, victim_dirty;
	cache_pkg::way_t  hit_way, victim_way;
	cache_pkg::tag_t  victim_tag;
	cache_pkg::line_u hit_line, victim_line;

	cache_ctrl u_cache_ctrl (
		.clk, .reset,
		.req_valid, .req_write, .req_addr, .req_wdata,
		.resp_valid, .resp_rdata, .resp_hit, .busy,
		.mem_read, .mem_write, .mem_addr, .mem_wdata, .mem_rvalid, .mem_rdata,
		.index, .lookup_tag, .word_offset, .word_data, .way_sel,
		.touch, .touch_way, .fill, .fill_line, .write_word, .clean,
		.hit, .hit_way, .hit_line, .victim_way, .victim_dirty, .victim_tag, .victim_line
	);

	for (genvar w = 0; w < `CACHE_NUM_WAYS; w++) begin : g_way
		cache_way u_cache_way (
			.clk, .reset, .index, .lookup_tag,
			.way_sel     (way_sel[w]),
			.touch, .touched_age, .fill,
			.fill_tag    (lookup_tag), // Fill always brings in the requested line
			.fill_line, .write_word, .word_offset, .word_data, .clean,
			.hit         (way_hit[w]),
			.valid       (way_valid[w]),
			.dirty       (way_dirty[w]),
			.age         (way_age[w]),
			.stored_tag  (way_tag[w]),
			.line        (way_line[w])
		);
	end

	way_select u_way_select (
		.way_hit, .way_valid, .way_dirty, .way_age, .way_tag, .way_line,
		.touch_way,
		.hit, .hit_way, .hit_line,
		.victim_way, .victim_dirty, .victim_tag, .victim_line,
		.touched_age
	);

endmodule

`default_nettype wire

/* tb/l2_cache_chk.sv */
// Protocol checks for the cache top level
// Memory strobes are exclusive and the response strobe is one cycle inside busy

`default_nettype none

module l2_cache_chk (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic resp_valid,
	input logic mem_read,
	input logic mem_write
);
	timeunit 1ns;
	timeprecision 100ps;

	mem_strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(mem_read && mem_write))
		else $error("mem_read and mem_write high in the same cycle");

	resp_inside_busy: assert property (@(posedge clk) disable iff (reset)
		resp_valid |-> busy)
		else $error("resp_valid high while busy is low");

	resp_single_cycle: assert property (@(posedge clk) disable iff (reset)
		$rose(resp_valid) |=> !resp_valid)
		else $error("resp_valid held for more than one cycle");

endmodule

bind l2_cache l2_cache_chk u_l2_cache_chk (
	.clk, .reset, .busy, .resp_valid, .mem_read, .mem_write
);

`default_nettype wire

/* tb/l2_cache_tb.sv */
// Testbench for the set-associative write-back cache
// Lower-level memory model with random read latency, word reference model
// and directed tests for hits, misses, write-back and LRU replacement

`default_nettype none

`include "cache_params.svh"

module l2_cache_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LINE_ADDR_WIDTH = `CACHE_TAG_WIDTH + `CACHE_INDEX_WIDTH;
	localparam int NUM_REQUESTS = 219; // Sum over all directed tests
	localparam logic [`CACHE_WORD_WIDTH-1:0] INIT_BASE = 32'h5A00_0000;

	logic clk;
	logic reset;
	logic req_valid;
	logic req_write;
	logic [`CACHE_ADDR_WIDTH-1:0] req_addr;
	logic [`CACHE_WORD_WIDTH-1:0] req_wdata;
	logic resp_valid;
	logic [`CACHE_WORD_WIDTH-1:0] resp_rdata;
	logic resp_hit;
	logic busy;
	logic mem_read;
	logic mem_write;
	logic [LINE_ADDR_WIDTH-1:0] mem_addr;
	cache_pkg::line_u mem_wdata;
	logic mem_rvalid;
	cache_pkg::line_u mem_rdata;

	cache_pkg::line_u mem_lines [int];                  // Lines written back by the DUT
	logic [`CACHE_WORD_WIDTH-1:0] ref_words [int];      // Words written by the requester
	int read_count;
	int write_count;
	logic [LINE_ADDR_WIDTH-1:0] last_read_addr;
	logic [LINE_ADDR_WIDTH-1:0] last_write_addr;
	cache_pkg::line_u last_write_line;
	string test_name;

	l2_cache u_l2_cache (
		.clk, .reset,
		.req_valid, .req_write, .req_addr, .req_wdata,
		.resp_valid, .resp_rdata, .resp_hit, .busy,
		.mem_read, .mem_write, .mem_addr, .mem_wdata, .mem_rvalid, .mem_rdata
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic int word_addr(int tag, int index, int offset);
		return tag * 64 + index * 4 + offset;
	endfunction

	// Untouched memory holds its word address plus a constant
	function automatic logic [`CACHE_WORD_WIDTH-1:0] expected_word(int addr);
		if (ref_words.exists(addr))
			return ref_words[addr];
		return INIT_BASE + 32'(addr);
	endfunction

	function automatic cache_pkg::line_u memory_line(int line_addr);
		cache_pkg::line_u fresh;
		if (mem_lines.exists(line_addr))
			return mem_lines[line_addr];
		for (int w = 0; w < `CACHE_WORDS_PER_LINE; w++)
			fresh.words[w] = INIT_BASE + 32'(line_addr * `CACHE_WORDS_PER_LINE + w);
		return fresh;
	endfunction

	task automatic stop_on_error(string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(string label, logic [31:0] expected, logic [31:0] actual);
		assert (actual === expected)
			else stop_on_error($sformatf("[FAIL] %s %s: expected %h, actual %h",
				test_name, label, expected, actual));
	endtask

	// Memory samples strobes on the falling edge and answers 1 to 4 cycles later
	initial begin : memory_model
		int countdown;
		logic pending;
		logic [LINE_ADDR_WIDTH-1:0] pending_addr;
		countdown = 0;
		pending = 1'b0;
		pending_addr = '0;
		forever begin
			@(negedge clk);
			mem_rvalid = 1'b0;
			if (mem_write) begin
				mem_lines[int'(mem_addr)] = mem_wdata;
				last_write_addr = mem_addr;
				last_write_line = mem_wdata;
				write_count++;
			end
			if (mem_read) begin
				last_read_addr = mem_addr;
				read_count++;
				pending = 1'b1;
				pending_addr = mem_addr;
				countdown = int'($urandom_range(4, 1));
			end else if (pending) begin
				countdown--;
				if (countdown == 0) begin
					mem_rvalid = 1'b1;
					mem_rdata = memory_line(int'(pending_addr));
					pending = 1'b0;
				end
			end
		end
	end

	// One request, waits for resp_valid and counts cycles from the req_valid cycle
	task automatic issue_request(input logic is_write, input int addr,
			input logic [31:0] wdata, output logic [31:0] rdata,
			output logic hit, output int cycles);
		@(negedge clk);
		req_valid = 1'b1;
		req_write = is_write;
		req_addr = addr[`CACHE_ADDR_WIDTH-1:0];
		req_wdata = wdata;
		cycles = 0;
		do begin
			@(negedge clk);
			req_valid = 1'b0;
			cycles++;
			check_value("busy while waiting", 32'd1, 32'(busy)); // Up to the response cycle
		end while (!resp_valid);
		rdata = resp_rdata;
		hit = resp_hit;
		if (is_write)
			ref_words[addr] = wdata;
	endtask

	task automatic read_expect(int addr, logic exp_hit, output int cycles);
		logic [31:0] rdata;
		logic hit;
		issue_request(1'b0, addr, 32'h0, rdata, hit, cycles);
		check_value($sformatf("read data @%h", addr), expected_word(addr), rdata);
		check_value($sformatf("read hit @%h", addr), 32'(exp_hit), 32'(hit));
	endtask

	task automatic write_expect(int addr, logic [31:0] data, logic exp_hit);
		logic [31:0] rdata;
		logic hit;
		int cycles;
		issue_request(1'b1, addr, data, rdata, hit, cycles);
		check_value($sformatf("write hit @%h", addr), 32'(exp_hit), 32'(hit));
	endtask

	task automatic check_idle_after_reset();
		test_name = "idle_after_reset";
		check_value("busy", 32'd0, 32'(busy));
		check_value("resp_valid", 32'd0, 32'(resp_valid));
		check_value("mem_read", 32'd0, 32'(mem_read));
		check_value("mem_write", 32'd0, 32'(mem_write));
	endtask

	task automatic miss_then_hit();
		int reads_before;
		int cycles;
		test_name = "miss_then_hit";
		reads_before = read_count;
		read_expect(word_addr(3, 1, 2), 1'b0, cycles);
		check_value("mem_read count", 32'(reads_before + 1), 32'(read_count));
		check_value("mem_read addr", 32'(word_addr(3, 1, 0) / 4), 32'(last_read_addr));
		read_expect(word_addr(3, 1, 2), 1'b1, cycles);
		check_value("hit latency", 32'd2, 32'(cycles));
	endtask

	task automatic write_then_read();
		int cycles;
		test_name = "write_then_read";
		write_expect(word_addr(3, 1, 1), 32'hCAFE_0001, 1'b1);
		read_expect(word_addr(3, 1, 1), 1'b1, cycles);
	endtask

	task automatic dirty_victim_writeback();
		int writes_before;
		int cycles;
		test_name = "dirty_victim_writeback";
		writes_before = write_count;
		read_expect(word_addr(1, 2, 0), 1'b0, cycles);
		write_expect(word_addr(1, 2, 3), 32'h1234_5678, 1'b1);
		for (int t = 2; t <= 4; t++)
			read_expect(word_addr(t, 2, 0), 1'b0, cycles); // Fills the free ways
		read_expect(word_addr(5, 2, 0), 1'b0, cycles);
		check_value("mem_write count", 32'(writes_before + 1), 32'(write_count));
		check_value("mem_write addr", 32'(word_addr(1, 2, 0) / 4), 32'(last_write_addr));
		for (int w = 0; w < `CACHE_WORDS_PER_LINE; w++)
			check_value($sformatf("written word %0d", w), expected_word(word_addr(1, 2, w)),
				last_write_line.words[w]);
		read_expect(word_addr(1, 2, 3), 1'b0, cycles); // Comes back from memory
	endtask

	task automatic lru_eviction_order();
		int cycles;
		test_name = "lru_eviction_order";
		for (int t = 1; t <= 4; t++)
			read_expect(word_addr(t, 3, 0), 1'b0, cycles);
		read_expect(word_addr(1, 3, 1), 1'b1, cycles); // A becomes most recent
		read_expect(word_addr(5, 3, 0), 1'b0, cycles);
		read_expect(word_addr(2, 3, 0), 1'b0, cycles); // B was the victim
		read_expect(word_addr(1, 3, 2), 1'b1, cycles);
	endtask

	task automatic random_traffic();
		logic [31:0] rdata;
		logic [31:0] wdata;
		logic hit;
		int cycles;
		int addr;
		test_name = "random_traffic";
		for (int i = 0; i < 200; i++) begin
			addr = int'($urandom_range(511, 0)); // Eight tags per set, forces evictions
			if ($urandom_range(1, 0) == 1) begin
				wdata = $urandom();
				issue_request(1'b1, addr, wdata, rdata, hit, cycles);
			end else begin
				issue_request(1'b0, addr, 32'h0, rdata, hit, cycles);
				check_value($sformatf("read @%h", addr), expected_word(addr), rdata);
			end
		end
	endtask

	initial begin : watchdog
		repeat (10 + NUM_REQUESTS * 40) @(posedge clk);
		$display("Timeout: the tests did not finish within the cycle budget");
		$display("Errors found");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		void'($urandom(8437));
		reset = 1'b1;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		mem_rvalid = 1'b0;
		mem_rdata = '0;
		read_count = 0;
		write_count = 0;
		last_read_addr = '0;
		last_write_addr = '0;
		last_write_line = '0;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		check_idle_after_reset();
		miss_then_hit();
		write_then_read();
		dirty_victim_writeback();
		lru_eviction_order();
		random_traffic();
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/cache_pkg.sv
hw/cache_way.sv
hw/way_select.sv
hw/cache_ctrl.sv
hw/l2_cache.sv
tb/l2_cache_chk.sv
tb/l2_cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module l2_cache_tb -o l2_cache_sim

output=$(./obj_dir/l2_cache_sim || true)
echo "$output"

if echo "$output" | grep -qx "No errors"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
